/* design/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [6:0] opcode_t;

  localparam xlen_t INSN_BYTES = 32'd4;

  // Base opcodes kept by this core
  localparam opcode_t OPCODE_LUI     = 7'b01_101_11;
  localparam opcode_t OPCODE_AUIPC   = 7'b00_101_11;
  localparam opcode_t OPCODE_REG_IMM = 7'b00_100_11;
  localparam opcode_t OPCODE_REG_REG = 7'b01_100_11;
  localparam opcode_t OPCODE_BRANCH  = 7'b11_000_11;
  localparam opcode_t OPCODE_JAL     = 7'b11_011_11;
  localparam opcode_t OPCODE_JALR    = 7'b11_001_11;
  localparam opcode_t OPCODE_ENVIRON = 7'b11_100_11;

  // Selects SUB and the arithmetic right shifts
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_SRL_SRA = 3'b101;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
    ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_IMM, ALU_PC_IMM, ALU_LINK
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } branch_op_e;

  // What occupies writeback in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

endpackage

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_we,
  input  reg_idx_t i_rd,
  input  xlen_t    i_rd_data,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  output xlen_t    o_rs1_data,
  output xlen_t    o_rs2_data
);

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // x0 reads as zero whatever the array holds
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // Decode never lets a write reach x0, so its storage stays zero
  assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`default_nettype none

module decode_stage import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  xlen_t         i_pc,
  input  insn_t         i_insn,
  input  logic          i_flush,
  input  logic          i_wb_we,
  input  reg_idx_t      i_wb_rd,
  input  xlen_t         i_wb_data,
  output xlen_t         o_pc,
  output insn_t         o_insn,
  output cycle_status_e o_status,
  output reg_idx_t      o_rs1,
  output reg_idx_t      o_rs2,
  output reg_idx_t      o_rd,
  output xlen_t         o_rs1_data,
  output xlen_t         o_rs2_data,
  output xlen_t         o_imm,
  output alu_op_e       o_alu_op,
  output branch_op_e    o_branch_op,
  output logic          o_we,
  output logic          o_halt
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       alt;
  logic       imm_ok;
  logic       reg_ok;
  logic       valid;
  logic       writes_rd;
  xlen_t      imm_i, imm_b, imm_j, imm_u;
  xlen_t      rf_rs1_data, rf_rs2_data;

  function automatic alu_op_e alu_op_for(logic [2:0] f3, logic sub_or_sra);
    case (f3)
      FUNCT3_ADD_SUB: alu_op_for = sub_or_sra ? ALU_SUB : ALU_ADD;
      FUNCT3_SLL:     alu_op_for = ALU_SLL;
      FUNCT3_SLT:     alu_op_for = ALU_SLT;
      FUNCT3_SLTU:    alu_op_for = ALU_SLTU;
      FUNCT3_XOR:     alu_op_for = ALU_XOR;
      FUNCT3_SRL_SRA: alu_op_for = sub_or_sra ? ALU_SRA : ALU_SRL;
      FUNCT3_OR:      alu_op_for = ALU_OR;
      FUNCT3_AND:     alu_op_for = ALU_AND;
      default:        alu_op_for = ALU_ADD;
    endcase
  endfunction

  // Decode register, a squash leaves a bubble behind
  always_ff @(posedge clk) begin
    if (rst || i_flush) begin
      o_pc     <= '0;
      o_insn   <= '0;
      o_status <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
    end else begin
      o_pc     <= i_pc;
      o_insn   <= i_insn;
      o_status <= CYCLE_NO_STALL;
    end
  end

  assign opcode = o_insn[6:0];
  assign funct3 = o_insn[14:12];
  assign funct7 = o_insn[31:25];
  assign o_rd   = o_insn[11:7];
  assign o_rs1  = o_insn[19:15];
  assign o_rs2  = o_insn[24:20];

  assign imm_i = {{20{o_insn[31]}}, o_insn[31:20]};
  assign imm_b = {{19{o_insn[31]}}, o_insn[31], o_insn[7], o_insn[30:25], o_insn[11:8], 1'b0};
  assign imm_j = {{11{o_insn[31]}}, o_insn[31], o_insn[19:12], o_insn[20], o_insn[30:21], 1'b0};
  assign imm_u = {o_insn[31:12], 12'b0};

  // Shift encodings only allow a zero or alternate funct7
  assign alt    = (funct7 == FUNCT7_ALT);
  assign imm_ok = (funct3 == FUNCT3_SLL) ? (funct7 == '0) :
                  (funct3 == FUNCT3_SRL_SRA) ? (funct7 == '0 || alt) : 1'b1;
  assign reg_ok = (funct7 == '0) ||
                  (alt && (funct3 == FUNCT3_ADD_SUB || funct3 == FUNCT3_SRL_SRA));

  always_comb begin
    valid       = 1'b1;
    writes_rd   = 1'b0;
    o_halt      = 1'b0;
    o_imm       = imm_i;
    o_alu_op    = ALU_ADD;
    o_branch_op = BR_NONE;
    case (opcode)
      OPCODE_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = ALU_PASS_IMM;
        writes_rd = 1'b1;
      end
      OPCODE_AUIPC: begin
        o_imm     = imm_u;
        o_alu_op  = ALU_PC_IMM;
        writes_rd = 1'b1;
      end
      OPCODE_REG_IMM: begin
        o_alu_op  = alu_op_for(funct3, alt && funct3 == FUNCT3_SRL_SRA);
        writes_rd = 1'b1;
        valid     = imm_ok;
      end
      OPCODE_REG_REG: begin
        o_alu_op  = alu_op_for(funct3, alt);
        writes_rd = 1'b1;
        valid     = reg_ok;
      end
      OPCODE_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          FUNCT3_BEQ:  o_branch_op = BR_EQ;
          FUNCT3_BNE:  o_branch_op = BR_NE;
          FUNCT3_BLT:  o_branch_op = BR_LT;
          FUNCT3_BGE:  o_branch_op = BR_GE;
          FUNCT3_BLTU: o_branch_op = BR_LTU;
          FUNCT3_BGEU: o_branch_op = BR_GEU;
          default:     valid = 1'b0;
        endcase
      end
      OPCODE_JAL: begin
        o_imm       = imm_j;
        o_alu_op    = ALU_LINK;
        o_branch_op = BR_JAL;
        writes_rd   = 1'b1;
      end
      OPCODE_JALR: begin
        o_alu_op    = ALU_LINK;
        o_branch_op = BR_JALR;
        writes_rd   = 1'b1;
        valid       = (funct3 == 3'b000);
      end
      OPCODE_ENVIRON: begin
        // Only ECALL, which halts the core
        o_halt = (o_insn[31:7] == '0);
        valid  = o_halt;
      end
      default: valid = 1'b0;
    endcase
    if (!valid) begin
      writes_rd   = 1'b0;
      o_branch_op = BR_NONE;
    end
  end

  assign o_we = writes_rd && (o_rd != '0);

  reg_file i_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_we       (i_wb_we),
    .i_rd       (i_wb_rd),
    .i_rd_data  (i_wb_data),
    .i_rs1      (o_rs1),
    .i_rs2      (o_rs2),
    .o_rs1_data (rf_rs1_data),
    .o_rs2_data (rf_rs2_data)
  );

  // WD bypass, the register file is written at the end of this cycle
  assign o_rs1_data = (i_wb_we && i_wb_rd == o_rs1) ? i_wb_data : rf_rs1_data;
  assign o_rs2_data = (i_wb_we && i_wb_rd == o_rs2) ? i_wb_data : rf_rs2_data;

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`default_nettype none

module execute_stage import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_flush,
  input  xlen_t         i_pc,
  input  insn_t         i_insn,
  input  cycle_status_e i_status,
  input  reg_idx_t      i_rs1,
  input  reg_idx_t      i_rs2,
  input  reg_idx_t      i_rd,
  input  xlen_t         i_rs1_data,
  input  xlen_t         i_rs2_data,
  input  xlen_t         i_imm,
  input  alu_op_e       i_alu_op,
  input  branch_op_e    i_branch_op,
  input  logic          i_we,
  input  logic          i_halt,
  input  logic          i_mem_we,
  input  reg_idx_t      i_mem_rd,
  input  xlen_t         i_mem_data,
  input  logic          i_wb_we,
  input  reg_idx_t      i_wb_rd,
  input  xlen_t         i_wb_data,
  output xlen_t         o_pc,
  output insn_t         o_insn,
  output cycle_status_e o_status,
  output reg_idx_t      o_rd,
  output xlen_t         o_result,
  output logic          o_we,
  output logic          o_halt,
  output logic          o_redirect,
  output xlen_t         o_redirect_pc
);

  alu_op_e    alu_op;
  branch_op_e branch_op;
  reg_idx_t   rs1, rs2;
  xlen_t      rs1_data, rs2_data, imm;
  xlen_t      op_a, op_rs2, op_b;
  xlen_t      pc_target, jalr_sum;
  logic [4:0] shamt;

  function automatic xlen_t bypass(
    reg_idx_t idx,
    xlen_t    rf_val,
    logic     mem_we,
    reg_idx_t mem_rd,
    xlen_t    mem_val,
    logic     wb_we,
    reg_idx_t wb_rd,
    xlen_t    wb_val
  );
    // The younger producer in memory wins over writeback
    if (mem_we && mem_rd == idx) begin
      bypass = mem_val;
    end else if (wb_we && wb_rd == idx) begin
      bypass = wb_val;
    end else begin
      bypass = rf_val;
    end
  endfunction

  always_ff @(posedge clk) begin
    if (rst || i_flush) begin
      o_pc      <= '0;
      o_insn    <= '0;
      o_status  <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
      alu_op    <= ALU_ADD;
      branch_op <= BR_NONE;
      o_we      <= 1'b0;
      o_halt    <= 1'b0;
    end else begin
      o_pc      <= i_pc;
      o_insn    <= i_insn;
      o_status  <= i_status;
      alu_op    <= i_alu_op;
      branch_op <= i_branch_op;
      o_we      <= i_we;
      o_halt    <= i_halt;
    end
  end

  // Operand payload, meaningless while o_we and branch_op are cleared
  always_ff @(posedge clk) begin
    rs1      <= i_rs1;
    rs2      <= i_rs2;
    o_rd     <= i_rd;
    rs1_data <= i_rs1_data;
    rs2_data <= i_rs2_data;
    imm      <= i_imm;
  end

  assign op_a   = bypass(rs1, rs1_data, i_mem_we, i_mem_rd, i_mem_data,
                         i_wb_we, i_wb_rd, i_wb_data);
  assign op_rs2 = bypass(rs2, rs2_data, i_mem_we, i_mem_rd, i_mem_data,
                         i_wb_we, i_wb_rd, i_wb_data);
  assign op_b   = (o_insn[6:0] == OPCODE_REG_REG) ? op_rs2 : imm;
  assign shamt  = op_b[4:0];

  assign pc_target = o_pc + imm;
  assign jalr_sum  = op_a + imm;

  always_comb begin
    case (alu_op)
      ALU_ADD:      o_result = op_a + op_b;
      ALU_SUB:      o_result = op_a - op_b;
      ALU_SLL:      o_result = op_a << shamt;
      ALU_SLT:      o_result = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:     o_result = xlen_t'(op_a < op_b);
      ALU_XOR:      o_result = op_a ^ op_b;
      ALU_SRL:      o_result = op_a >> shamt;
      ALU_SRA:      o_result = $signed(op_a) >>> shamt;
      ALU_OR:       o_result = op_a | op_b;
      ALU_AND:      o_result = op_a & op_b;
      ALU_PASS_IMM: o_result = imm;
      ALU_PC_IMM:   o_result = pc_target;
      ALU_LINK:     o_result = o_pc + INSN_BYTES;
      default:      o_result = '0;
    endcase
  end

  always_comb begin
    case (branch_op)
      BR_EQ:   o_redirect = (op_a == op_rs2);
      BR_NE:   o_redirect = (op_a != op_rs2);
      BR_LT:   o_redirect = ($signed(op_a) < $signed(op_rs2));
      BR_GE:   o_redirect = ($signed(op_a) >= $signed(op_rs2));
      BR_LTU:  o_redirect = (op_a < op_rs2);
      BR_GEU:  o_redirect = (op_a >= op_rs2);
      BR_JAL:  o_redirect = 1'b1;
      BR_JALR: o_redirect = 1'b1;
      default: o_redirect = 1'b0;
    endcase
  end

  assign o_redirect_pc = (branch_op == BR_JALR) ? {jalr_sum[31:1], 1'b0} : pc_target;

  // Fetch has no way to handle a misaligned target
  assert property (@(posedge clk) disable iff (rst) o_redirect |-> o_redirect_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/pipe_core.sv */
`default_nettype none

module pipe_core import rv_pkg::*; #(
  parameter xlen_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst,
  output xlen_t         o_pc,
  input  insn_t         i_insn,
  output logic          o_halt,
  output xlen_t         o_wb_pc,
  output insn_t         o_wb_insn,
  output cycle_status_e o_wb_status,
  output logic          o_wb_we,
  output reg_idx_t      o_wb_rd,
  output xlen_t         o_wb_data
);

  logic          redirect;
  xlen_t         redirect_pc;
  logic          halt_seen;

  xlen_t         d_pc, d_imm, d_rs1_data, d_rs2_data;
  insn_t         d_insn;
  cycle_status_e d_status;
  reg_idx_t      d_rs1, d_rs2, d_rd;
  alu_op_e       d_alu_op;
  branch_op_e    d_branch_op;
  logic          d_we, d_halt;

  xlen_t         x_pc, x_result;
  insn_t         x_insn;
  cycle_status_e x_status;
  reg_idx_t      x_rd;
  logic          x_we, x_halt;

  xlen_t         m_pc, m_data;
  insn_t         m_insn;
  cycle_status_e m_status;
  reg_idx_t      m_rd;
  logic          m_we, m_halt;

  // Fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      o_pc <= RESET_PC;
    end else begin
      o_pc <= redirect ? redirect_pc : o_pc + INSN_BYTES;
    end
  end

  decode_stage i_decode (
    .clk         (clk),
    .rst         (rst),
    .i_pc        (o_pc),
    .i_insn      (i_insn),
    .i_flush     (redirect),
    .i_wb_we     (o_wb_we),
    .i_wb_rd     (o_wb_rd),
    .i_wb_data   (o_wb_data),
    .o_pc        (d_pc),
    .o_insn      (d_insn),
    .o_status    (d_status),
    .o_rs1       (d_rs1),
    .o_rs2       (d_rs2),
    .o_rd        (d_rd),
    .o_rs1_data  (d_rs1_data),
    .o_rs2_data  (d_rs2_data),
    .o_imm       (d_imm),
    .o_alu_op    (d_alu_op),
    .o_branch_op (d_branch_op),
    .o_we        (d_we),
    .o_halt      (d_halt)
  );

  execute_stage i_execute (
    .clk (clk), .rst (rst), .i_flush (redirect),
    .i_pc (d_pc), .i_insn (d_insn), .i_status (d_status),
    .i_rs1 (d_rs1), .i_rs2 (d_rs2), .i_rd (d_rd),
    .i_rs1_data (d_rs1_data), .i_rs2_data (d_rs2_data), .i_imm (d_imm),
    .i_alu_op (d_alu_op), .i_branch_op (d_branch_op), .i_we (d_we), .i_halt (d_halt),
    .i_mem_we (m_we), .i_mem_rd (m_rd), .i_mem_data (m_data),
    .i_wb_we (o_wb_we), .i_wb_rd (o_wb_rd), .i_wb_data (o_wb_data),
    .o_pc (x_pc), .o_insn (x_insn), .o_status (x_status),
    .o_rd (x_rd), .o_result (x_result), .o_we (x_we), .o_halt (x_halt),
    .o_redirect (redirect), .o_redirect_pc (redirect_pc)
  );

  // Memory stage kept as the MX bypass point
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc      <= '0;
      m_insn    <= '0;
      m_status  <= CYCLE_RESET;
      m_we      <= 1'b0;
      m_halt    <= 1'b0;
      halt_seen <= 1'b0;
    end else begin
      m_pc      <= x_pc;
      m_insn    <= x_insn;
      m_status  <= x_status;
      // Anything younger than an ECALL must not retire a write
      m_we      <= x_we && !halt_seen;
      m_halt    <= x_halt;
      halt_seen <= halt_seen || x_halt;
    end
  end

  always_ff @(posedge clk) begin
    m_rd   <= x_rd;
    m_data <= x_result;
  end

  // Writeback drives the register file port and the trace
  always_ff @(posedge clk) begin
    if (rst) begin
      o_wb_pc     <= '0;
      o_wb_insn   <= '0;
      o_wb_status <= CYCLE_RESET;
      o_wb_we     <= 1'b0;
      o_halt      <= 1'b0;
    end else begin
      o_wb_pc     <= m_pc;
      o_wb_insn   <= m_insn;
      o_wb_status <= m_status;
      o_wb_we     <= m_we;
      o_halt      <= o_halt || m_halt;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_rd   <= m_rd;
    o_wb_data <= m_data;
  end

endmodule

`default_nettype wire

/* sim/tb_pipe_core.sv */
`default_nettype none

module tb_pipe_core import rv_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    HALT_TIMEOUT = 200;
  localparam int    QUIET_CYCLES = 10;
  localparam int    RESET_CYCLES = 8;
  localparam int    PIPE_DEPTH   = 4;
  localparam int    MEM_WORDS    = 64;
  localparam xlen_t RESET_PC     = 32'h0000_0000;

  logic          clk = 1'b0;
  logic          rst;
  xlen_t         pc;
  insn_t         insn;
  logic          halt;
  xlen_t         wb_pc;
  insn_t         wb_insn;
  cycle_status_e wb_status;
  logic          wb_we;
  reg_idx_t      wb_rd;
  xlen_t         wb_data;

  insn_t imem [MEM_WORDS];

  // Current test as read from the test file
  string test_name;
  int    exp_redirects;
  insn_t prog [$];
  int    exp_rd [$];
  xlen_t exp_val [$];

  int    bubble_run;
  int    redirects_seen;
  int    writes_checked;
  insn_t last_insn;
  xlen_t next_pc;
  logic  pc_known;
  int    tests = 0;
  int    checks = 0;
  int    errors = 0;

  always #10 clk = ~clk;

  // Instruction memory answers within the same cycle
  assign insn = imem[pc[7:2]];

  pipe_core #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .o_pc        (pc),
    .i_insn      (insn),
    .o_halt      (halt),
    .o_wb_pc     (wb_pc),
    .o_wb_insn   (wb_insn),
    .o_wb_status (wb_status),
    .o_wb_we     (wb_we),
    .o_wb_rd     (wb_rd),
    .o_wb_data   (wb_data)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Filler is addi x0 with the word index as its immediate
  function automatic insn_t fill_word(int addr);
    return {12'(addr), 20'h00013};
  endfunction

  function automatic logic is_control_transfer(insn_t word);
    return word[6:0] == OPCODE_BRANCH || word[6:0] == OPCODE_JAL ||
           word[6:0] == OPCODE_JALR;
  endfunction

  task automatic load_program();
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = (a < prog.size()) ? prog[a] : fill_word(a);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    // Memory is rewritten while the core is held
    @(negedge clk);
    load_program();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic observe_writeback();
    if (wb_status == CYCLE_TAKEN_BRANCH) begin
      bubble_run++;
      check_value("o_wb_we", 32'(wb_we), 32'd0);
    end else begin
      // Bubbles only ever follow a taken control transfer
      if (bubble_run != 0) begin
        redirects_seen++;
        check_value("taken-branch bubble run", bubble_run, 2);
        if (!is_control_transfer(last_insn)) begin
          errors++;
          $display("test %s: bubbles at %0d ns follow an instruction that cannot jump",
                   test_name, $time);
        end
        bubble_run = 0;
        pc_known   = 1'b0;
      end
      if (wb_status == CYCLE_NO_STALL) begin
        // Without a redirect the next instruction sits one word further on
        if (pc_known) begin
          check_value("o_wb_pc", wb_pc, next_pc);
        end
        check_value("o_wb_insn", wb_insn, imem[wb_pc[7:2]]);
        last_insn = wb_insn;
        next_pc   = wb_pc + 32'd4;
        pc_known  = 1'b1;
      end
      if (wb_we) begin
        if (exp_rd.size() == 0) begin
          errors++;
          $display("test %s: unexpected write of %h to x%0d at %0d ns",
                   test_name, wb_data, wb_rd, $time);
        end else begin
          check_value("o_wb_rd", 32'(wb_rd), exp_rd.pop_front());
          check_value("o_wb_data", wb_data, exp_val.pop_front());
          writes_checked++;
        end
      end
    end
  endtask

  task automatic run_test();
    int cycles;
    int errors_before;
    errors_before  = errors;
    bubble_run     = 0;
    redirects_seen = 0;
    writes_checked = 0;
    last_insn      = '0;
    next_pc        = RESET_PC;
    pc_known       = 1'b1;
    tests++;
    if (prog.size() > MEM_WORDS) begin
      errors++;
      $display("test %s: program of %0d words does not fit", test_name, prog.size());
    end
    apply_reset();
    cycles = 0;
    do begin
      @(negedge clk);
      if (cycles == 0) begin
        check_value("o_halt", 32'(halt), 32'd0);
        check_value("o_wb_we", 32'(wb_we), 32'd0);
        check_value("o_pc", pc, RESET_PC);
        check_value("o_wb_pc", wb_pc, 32'd0);
        check_value("o_wb_insn", wb_insn, 32'd0);
      end
      // Nothing fetched yet has reached writeback
      if (cycles < PIPE_DEPTH) begin
        check_value("o_wb_status", 32'(wb_status), 32'(CYCLE_RESET));
      end
      observe_writeback();
      cycles++;
    end while (!halt && cycles < HALT_TIMEOUT);
    if (!halt) begin
      errors++;
      $display("test %s: program never halted within %0d cycles", test_name, HALT_TIMEOUT);
    end else begin
      if (exp_rd.size() != 0) begin
        errors++;
        $display("test %s: %0d expected writes never happened", test_name, exp_rd.size());
      end
      check_value("taken redirects", redirects_seen, exp_redirects);
      for (int i = 0; i < QUIET_CYCLES; i++) begin
        @(negedge clk);
        check_value("o_wb_we", 32'(wb_we), 32'd0);
      end
    end
    $display("test %s: %0d writes checked, %s", test_name, writes_checked,
             (errors == errors_before) ? "passed" : "failed");
  endtask

  initial begin
    string tok;
    string rest;
    int    fd;
    int    code;
    int    rd;
    int    count;
    insn_t word;
    xlen_t value;
    rst = 1'b1;
    for (int a = 0; a < MEM_WORDS; a++) begin
      imem[a] = fill_word(a);
    end
    fd = $fopen("sim/pipe_core_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/pipe_core_tests.txt");
      $display("Errors found");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          code = $fgets(rest, fd);
        end else if (tok == "test") begin
          code = $fscanf(fd, "%s %d", test_name, exp_redirects);
          prog.delete();
          exp_rd.delete();
          exp_val.delete();
        end else if (tok == "p") begin
          code = $fscanf(fd, "%d", count);
          for (int i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", word);
            prog.push_back(word);
          end
        end else if (tok == "w") begin
          code = $fscanf(fd, "%d %h", rd, value);
          exp_rd.push_back(rd);
          exp_val.push_back(value);
        end else if (tok == "end") begin
          run_test();
        end else begin
          errors++;
          $display("unknown entry %s in the test file", tok);
        end
      end
      $fclose(fd);
      if (tests == 0) begin
        errors++;
        $display("the test file held no tests");
      end
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim/pipe_core_tests.txt */
# test <name> <taken redirects> / p <word count> <instruction words, hex> from address 0
# w <rd> <expected value, hex> in writeback order / end runs the test
test alu 0
p 4 00500093 ffd08113 00409193 40118233
p 4 fff14293 4012d313 01c2d393 0012a433
p 4 0012b4b3 12345537 00001597 00708013
p 4 00a00633 00a1e6b3 0036f733 4012d7b3
p 4 ffe2a813 0ff6f893 00000073 00100913
w 1 00000005
w 2 00000002
w 3 00000050
w 4 0000004b
w 5 fffffffd
w 6 fffffffe
w 7 0000000f
w 8 00000001
w 9 00000000
w 10 12345000
w 11 00001028
w 12 12345000
w 13 12345050
w 14 00000050
w 15 ffffffff
w 16 00000001
w 17 00000050
end
test branch 5
p 4 00300093 00300113 00208663 00100193
p 4 00200193 00209463 fff00213 0040e463
p 4 00900293 0040c463 00c0036f 00100393
p 4 00200393 04800413 000404e7 00100513
p 4 00200513 00300513 0040d463 00100593
p 2 00930633 00000073
w 1 00000003
w 2 00000003
w 4 ffffffff
w 6 0000002c
w 8 00000048
w 9 0000003c
w 12 00000068
end

/* build.f */
design/rv_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/pipe_core.sv
sim/tb_pipe_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_pipe_core \
  && ./obj_dir/Vtb_pipe_core > sim.log 2>&1 \
  || { echo "simulation did not build or run"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
